// File: src/icache_pkg.sv
/*
  L1 instruction cache shared definitions
  Request operations, controller states, fixed widths and the
  default cache geometry used by the top level
*/

package icache_pkg;

  // Request operation
  typedef enum logic
  {
    e_fetch = 1'b0,
    e_inval = 1'b1
  } icache_op_e;

  // Controller state
  //   e_ready   accepting requests, TV produces results
  //   e_miss    waiting for the fill block
  //   e_recover re-read arrays for the entry held in TL
  //   e_flush   clearing one set per cycle
  typedef enum logic [1:0]
  {
    e_ready   = 2'd0,
    e_miss    = 2'd1,
    e_recover = 2'd2,
    e_flush   = 2'd3
  } icache_state_e;

  // Address and instruction widths
  localparam int paddr_width_c       = 32;
  localparam int instr_width_c       = 32;

  // Index and block offset must fit in the untranslated bits
  localparam int page_offset_width_c = 12;

  // Default geometry
  localparam int sets_default_c        = 64;
  localparam int assoc_default_c       = 2;
  localparam int block_width_default_c = 128;

endpackage

// File: src/icache_if.sv
/*
  Instruction cache array interfaces
  Lookup path carries the read request, the compare tag and the
  per-way results. Fill path carries block writes and set flushes
*/

`timescale 1ns/10ps

interface icache_lookup_if
  #(parameter int sets_p        = icache_pkg::sets_default_c,
    parameter int assoc_p       = icache_pkg::assoc_default_c,
    parameter int block_width_p = icache_pkg::block_width_default_c);

  import icache_pkg::*;

  localparam int index_w = $clog2(sets_p);
  localparam int tag_w   = paddr_width_c - index_w - $clog2(block_width_p / 8);

  logic                                  rd_v;
  logic [index_w-1:0]                    index;
  logic [tag_w-1:0]                      ptag;
  logic [assoc_p-1:0]                    hit_way;
  logic [assoc_p-1:0]                    way_valid;
  logic [assoc_p-1:0][block_width_p-1:0] blocks;

  modport ctrl (output rd_v, index, ptag, input hit_way, way_valid, blocks);
  modport tags (input rd_v, index, ptag, output hit_way, way_valid);
  modport data (input rd_v, index, output blocks);

endinterface

interface icache_fill_if
  #(parameter int sets_p        = icache_pkg::sets_default_c,
    parameter int assoc_p       = icache_pkg::assoc_default_c,
    parameter int block_width_p = icache_pkg::block_width_default_c);

  import icache_pkg::*;

  localparam int index_w = $clog2(sets_p);
  localparam int tag_w   = paddr_width_c - index_w - $clog2(block_width_p / 8);

  logic                     wr_v;
  logic                     flush_v;
  logic [index_w-1:0]       index;
  logic [assoc_p-1:0]       way;
  logic [tag_w-1:0]         tag;
  logic [block_width_p-1:0] block;

  modport ctrl (output wr_v, flush_v, index, way, tag, block);
  modport tags (input wr_v, flush_v, index, way, tag);
  modport data (input wr_v, index, way, block);

endinterface

// File: src/icache_tag_array.sv
/*
  Instruction cache tag array
  Holds one tag and valid bit per way and set. A read registers the
  tags of the set, the compare against the TL physical tag is done
  on the registered values. Fills set tag and valid, a flush clears
  every valid bit of the set
*/

`timescale 1ns/10ps

module icache_tag_array
  #(parameter int sets_p        = icache_pkg::sets_default_c,
    parameter int assoc_p       = icache_pkg::assoc_default_c,
    parameter int block_width_p = icache_pkg::block_width_default_c)
  (input logic           clk_i,
   input logic           reset_i,
   icache_lookup_if.tags lookup,
   icache_fill_if.tags   fill
  );

  import icache_pkg::*;

  localparam int index_w  = $clog2(sets_p);
  localparam int offset_w = $clog2(block_width_p / 8);
  localparam int tag_w    = paddr_width_c - index_w - offset_w;

  logic [tag_w-1:0]   tag_mem [sets_p][assoc_p];
  logic [assoc_p-1:0] valid_mem [sets_p];

  logic [assoc_p-1:0][tag_w-1:0] tag_rd_r;
  logic [assoc_p-1:0]            valid_rd_r;

  //////////////////////////////
  // Storage
  //////////////////////////////
  always_ff @(posedge clk_i)
  begin
    for (int w = 0; w < assoc_p; w++)
    begin
      if (fill.wr_v && fill.way[w])
        tag_mem[fill.index][w] <= fill.tag;
      if (lookup.rd_v)
        tag_rd_r[w] <= tag_mem[lookup.index][w];
    end
  end

  // Valid bits are cleared by the controller's flush sweep
  always_ff @(posedge clk_i)
  begin
    if (fill.flush_v)
      valid_mem[fill.index] <= '0;
    else if (fill.wr_v)
      valid_mem[fill.index] <= valid_mem[fill.index] | fill.way;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      valid_rd_r <= '0;
    else if (lookup.rd_v)
      valid_rd_r <= valid_mem[lookup.index];
  end

  //////////////////////////////
  // Tag compare
  //////////////////////////////
  assign lookup.way_valid = valid_rd_r;

  always_comb
  begin
    for (int w = 0; w < assoc_p; w++)
      lookup.hit_way[w] = valid_rd_r[w] && (tag_rd_r[w] == lookup.ptag);
  end

  // A block is only ever filled into one way of its set
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(lookup.hit_way))
    else $error("tag array: hit_way %h is not one-hot", lookup.hit_way);

endmodule

// File: src/icache_data_array.sv
/*
  Instruction cache data array
  One full block per way and set. All ways of the indexed set are
  read together with one cycle latency, a fill writes the whole
  block into the selected way
*/

`timescale 1ns/10ps

module icache_data_array
  #(parameter int sets_p        = icache_pkg::sets_default_c,
    parameter int assoc_p       = icache_pkg::assoc_default_c,
    parameter int block_width_p = icache_pkg::block_width_default_c)
  (input logic           clk_i,
   icache_lookup_if.data lookup,
   icache_fill_if.data   fill
  );

  logic [block_width_p-1:0] block_mem [sets_p][assoc_p];

  always_ff @(posedge clk_i)
  begin
    for (int w = 0; w < assoc_p; w++)
    begin
      // Fill write into the one-hot way
      if (fill.wr_v && fill.way[w])
        block_mem[fill.index][w] <= fill.block;
      // Synchronous read, all ways
      if (lookup.rd_v)
        lookup.blocks[w] <= block_mem[lookup.index][w];
    end
  end

endmodule

// File: src/icache_lru.sv
/*
  Pseudo-tree LRU for the instruction cache
  Keeps assoc_p-1 tree bits per set. Node n has children 2n+1 and
  2n+2, a bit of 0 points left. Updates point the path away from
  the way used. The victim is the lowest invalid way, else the way
  the tree points to
*/

`timescale 1ns/10ps

module icache_lru
  #(parameter int sets_p  = icache_pkg::sets_default_c,
    parameter int assoc_p = icache_pkg::assoc_default_c,
    localparam int index_w = $clog2(sets_p))
  (input  logic               clk_i,
   input  logic               reset_i,
   input  logic               upd_v_i,
   input  logic [index_w-1:0] upd_index_i,
   input  logic [assoc_p-1:0] upd_way_i,
   input  logic [index_w-1:0] vic_index_i,
   input  logic [assoc_p-1:0] way_valid_i,
   output logic [assoc_p-1:0] victim_way_o
  );

  localparam int way_w  = $clog2(assoc_p);
  localparam int tree_w = assoc_p - 1;

  logic [tree_w-1:0]  lru_r [sets_p];
  logic [tree_w-1:0]  lru_n;
  logic [tree_w-1:0]  vic_bits;
  logic [way_w-1:0]   upd_id;
  logic [way_w-1:0]   tree_id;
  logic [assoc_p-1:0] invalid_sel;

  //////////////////////////////
  // Update path
  //////////////////////////////
  always_comb
  begin
    upd_id = '0;
    for (int w = 0; w < assoc_p; w++)
      if (upd_way_i[w])
        upd_id = upd_id | way_w'(w);
  end

  // Walk from the root, MSB of the way id picks the first branch
  always_comb
  begin
    int node;
    node  = 0;
    lru_n = lru_r[upd_index_i];
    for (int l = 0; l < way_w; l++)
    begin
      lru_n[node] = ~upd_id[way_w-1-l];
      node = 2 * node + 1 + int'(upd_id[way_w-1-l]);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int s = 0; s < sets_p; s++)
        lru_r[s] <= '0;
    end
    else if (upd_v_i)
      lru_r[upd_index_i] <= lru_n;
  end

  //////////////////////////////
  // Victim selection
  //////////////////////////////
  always_comb
  begin
    int node;
    node     = 0;
    vic_bits = lru_r[vic_index_i];
    tree_id  = '0;
    for (int l = 0; l < way_w; l++)
    begin
      tree_id = (tree_id << 1) | way_w'(vic_bits[node]);
      node = 2 * node + 1 + int'(vic_bits[node]);
    end
  end

  // Lowest invalid way wins, so scan downwards
  always_comb
  begin
    invalid_sel = '0;
    for (int w = assoc_p - 1; w >= 0; w--)
      if (!way_valid_i[w])
        invalid_sel = assoc_p'(1) << w;
  end

  assign victim_way_o = (|invalid_sel) ? invalid_sel : (assoc_p'(1) << tree_id);

endmodule

// File: src/icache_ctrl.sv
/*
  Instruction cache controller
  Decode, tag lookup (TL) and tag verify (TV) stages, the
  miss / recover / flush state machine and the output strobes.
  Misses request a whole block and the fill is written into the
  arrays and into TV in the same cycle
*/

`timescale 1ns/10ps

module icache_ctrl
  #(parameter int sets_p        = icache_pkg::sets_default_c,
    parameter int assoc_p       = icache_pkg::assoc_default_c,
    parameter int block_width_p = icache_pkg::block_width_default_c,
    localparam int index_w = $clog2(sets_p),
    localparam int tag_w   = icache_pkg::paddr_width_c - index_w - $clog2(block_width_p / 8))
  (input  logic                                     clk_i,
   input  logic                                     reset_i,
   input  logic [icache_pkg::paddr_width_c-1:0]     vaddr_i,
   input  icache_pkg::icache_op_e                   op_i,
   input  logic                                     v_i,
   output logic                                     yumi_o,
   input  logic [tag_w-1:0]                         ptag_i,
   output logic [icache_pkg::instr_width_c-1:0]     data_o,
   output logic                                     data_v_o,
   output logic                                     fence_v_o,
   input  logic                                     yumi_i,
   output logic                                     req_v_o,
   output logic [icache_pkg::paddr_width_c-1:0]     req_addr_o,
   input  logic                                     req_yumi_i,
   input  logic                                     fill_v_i,
   input  logic [block_width_p-1:0]                 fill_data_i,
   icache_lookup_if.ctrl                            lookup,
   icache_fill_if.ctrl                              fill,
   output logic                                     upd_v_o,
   output logic [index_w-1:0]                       upd_index_o,
   output logic [assoc_p-1:0]                       upd_way_o,
   output logic [index_w-1:0]                       vic_index_o,
   output logic [assoc_p-1:0]                       way_valid_o,
   input  logic [assoc_p-1:0]                       victim_way_i
  );

  import icache_pkg::*;

  localparam int offset_w = $clog2(block_width_p / 8);
  localparam int word_w   = $clog2(block_width_p / instr_width_c);
  localparam int page_w   = index_w + offset_w;

  if (page_w > page_offset_width_c)
  begin : g_way_size_check
    $error("icache way size exceeds the untranslated page offset");
  end

  icache_state_e state_r, state_n;
  logic          init_r;
  logic [index_w-1:0] flush_cnt_r;
  logic          flush_last;
  logic          tl_to_tv, tv_deq;

  // TL stage
  logic                     tl_v_r;
  logic [paddr_width_c-1:0] tl_addr_r;
  icache_op_e               tl_op_r;

  // TV stage
  logic                                  tv_v_r;
  logic                                  tv_hit_r;
  logic [paddr_width_c-1:0]              tv_addr_r;
  icache_op_e                            tv_op_r;
  logic [assoc_p-1:0]                    tv_way_r;
  logic [assoc_p-1:0]                    tv_valid_r;
  logic [assoc_p-1:0][block_width_p-1:0] tv_blocks_r;
  logic [assoc_p-1:0]                    victim_r;
  logic [block_width_p-1:0]              tv_block;
  logic [word_w-1:0]                     tv_word;
  logic [index_w-1:0]                    tv_index;

  //////////////////////////////
  // Stage control
  //////////////////////////////
  assign tv_deq   = (data_v_o | fence_v_o) & yumi_i;
  assign tl_to_tv = (state_r == e_ready) & tl_v_r & (~tv_v_r | tv_deq);
  // No accepts until the power-up sweep has cleared the tags
  assign yumi_o   = v_i & (state_r == e_ready) & ~init_r & (~tl_v_r | tl_to_tv);

  assign tv_index   = tv_addr_r[offset_w +: index_w];
  assign flush_last = (state_r == e_flush) && (flush_cnt_r == index_w'(sets_p - 1));

  //////////////////////////////
  // Array access
  //////////////////////////////
  assign lookup.rd_v  = yumi_o | (state_r == e_recover);
  assign lookup.index = (state_r == e_recover) ? tl_addr_r[offset_w +: index_w]
                                               : vaddr_i[offset_w +: index_w];
  assign lookup.ptag  = ptag_i;

  assign fill.wr_v    = fill_v_i & (state_r == e_miss);
  assign fill.flush_v = (state_r == e_flush);
  assign fill.index   = (state_r == e_flush) ? flush_cnt_r : tv_index;
  assign fill.way     = victim_r;
  assign fill.tag     = tv_addr_r[paddr_width_c-1 -: tag_w];
  assign fill.block   = fill_data_i;

  // LRU touches the way once, when the response is taken
  assign upd_v_o     = data_v_o & yumi_i;
  assign upd_index_o = tv_index;
  assign upd_way_o   = tv_way_r;
  assign vic_index_o = tv_index;
  assign way_valid_o = tv_valid_r;

  //////////////////////////////
  // TV outputs
  //////////////////////////////
  always_comb
  begin
    tv_block = '0;
    for (int w = 0; w < assoc_p; w++)
      if (tv_way_r[w])
        tv_block = tv_block | tv_blocks_r[w];
  end

  assign tv_word    = tv_addr_r[2 +: word_w];
  assign data_o     = tv_block[tv_word * instr_width_c +: instr_width_c];
  assign data_v_o   = (state_r == e_ready) & tv_v_r & (tv_op_r == e_fetch) & tv_hit_r;
  assign fence_v_o  = (state_r == e_ready) & tv_v_r & (tv_op_r == e_inval) & tv_hit_r;
  assign req_v_o    = (state_r == e_ready) & tv_v_r & (tv_op_r == e_fetch) & ~tv_hit_r;
  assign req_addr_o = {tv_addr_r[paddr_width_c-1:offset_w], {offset_w{1'b0}}};

  //////////////////////////////
  // State machine
  //////////////////////////////
  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_ready:
        if (init_r || (tv_v_r && tv_op_r == e_inval && !tv_hit_r))
          state_n = e_flush;
        else if (req_v_o && req_yumi_i)
          state_n = e_miss;
      e_miss:
        if (fill_v_i)
          state_n = e_recover;
      e_flush:
        if (flush_last)
          state_n = e_recover;
      default:
        state_n = e_ready;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r     <= e_ready;
      init_r      <= 1'b1;
      flush_cnt_r <= '0;
      tl_v_r      <= 1'b0;
      tv_v_r      <= 1'b0;
    end
    else
    begin
      state_r <= state_n;
      if (flush_last)
        init_r <= 1'b0;
      if (state_r == e_flush)
        flush_cnt_r <= flush_last ? '0 : flush_cnt_r + 1'b1;
      if (yumi_o)
        tl_v_r <= 1'b1;
      else if (tl_to_tv)
        tl_v_r <= 1'b0;
      if (tl_to_tv)
        tv_v_r <= 1'b1;
      else if (tv_deq)
        tv_v_r <= 1'b0;
    end
  end

  //////////////////////////////
  // Stage payload
  //////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (yumi_o)
    begin
      tl_addr_r <= vaddr_i;
      tl_op_r   <= op_i;
    end
    if (tl_to_tv)
    begin
      tv_addr_r   <= {ptag_i, tl_addr_r[page_w-1:0]};
      tv_op_r     <= tl_op_r;
      tv_way_r    <= lookup.hit_way;
      tv_valid_r  <= lookup.way_valid;
      tv_blocks_r <= lookup.blocks;
      tv_hit_r    <= (tl_op_r == e_fetch) && (|lookup.hit_way);
    end
    else if (fill.wr_v)
    begin
      // Fill block goes straight into TV and the request becomes a hit
      for (int w = 0; w < assoc_p; w++)
        if (victim_r[w])
          tv_blocks_r[w] <= fill_data_i;
      tv_way_r <= victim_r;
      tv_hit_r <= 1'b1;
    end
    else if (flush_last)
      tv_hit_r <= 1'b1;
    if (req_v_o && req_yumi_i)
      victim_r <= victim_way_i;
  end

  a_fill_in_miss: assert property (@(posedge clk_i) disable iff (reset_i)
    fill_v_i |-> state_r == e_miss)
    else $error("icache: fill_v_i outside of a miss");

  a_data_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    data_v_o && !yumi_i |=> data_v_o && $stable(data_o))
    else $error("icache: data_o changed while waiting for yumi_i");

endmodule

// File: src/icache_top.sv
/*
  L1 instruction cache top level
  Two-stage set-associative cache with pseudo-tree LRU. Connects
  the controller to the tag array, data array and LRU
*/

`timescale 1ns/10ps

module icache_top
  #(parameter int sets_p        = icache_pkg::sets_default_c,
    parameter int assoc_p       = icache_pkg::assoc_default_c,
    parameter int block_width_p = icache_pkg::block_width_default_c,
    localparam int tag_w = icache_pkg::paddr_width_c - $clog2(sets_p)
                           - $clog2(block_width_p / 8))
  (input  logic                                 clk_i,
   input  logic                                 reset_i,
   input  logic [icache_pkg::paddr_width_c-1:0] vaddr_i,
   input  icache_pkg::icache_op_e               op_i,
   input  logic                                 v_i,
   output logic                                 yumi_o,
   input  logic [tag_w-1:0]                     ptag_i,
   output logic [icache_pkg::instr_width_c-1:0] data_o,
   output logic                                 data_v_o,
   output logic                                 fence_v_o,
   input  logic                                 yumi_i,
   output logic                                 req_v_o,
   output logic [icache_pkg::paddr_width_c-1:0] req_addr_o,
   input  logic                                 req_yumi_i,
   input  logic                                 fill_v_i,
   input  logic [block_width_p-1:0]             fill_data_i
  );

  localparam int index_w = $clog2(sets_p);

  logic               upd_v;
  logic [index_w-1:0] upd_index;
  logic [assoc_p-1:0] upd_way;
  logic [index_w-1:0] vic_index;
  logic [assoc_p-1:0] way_valid;
  logic [assoc_p-1:0] victim_way;

  icache_lookup_if #(.sets_p(sets_p), .assoc_p(assoc_p), .block_width_p(block_width_p))
    lookup ();
  icache_fill_if #(.sets_p(sets_p), .assoc_p(assoc_p), .block_width_p(block_width_p))
    fill ();

  icache_ctrl #(.sets_p(sets_p), .assoc_p(assoc_p), .block_width_p(block_width_p)) ctrl
  (
    .clk_i(clk_i), .reset_i(reset_i),
    .vaddr_i(vaddr_i), .op_i(op_i), .v_i(v_i), .yumi_o(yumi_o), .ptag_i(ptag_i),
    .data_o(data_o), .data_v_o(data_v_o), .fence_v_o(fence_v_o), .yumi_i(yumi_i),
    .req_v_o(req_v_o), .req_addr_o(req_addr_o), .req_yumi_i(req_yumi_i),
    .fill_v_i(fill_v_i), .fill_data_i(fill_data_i),
    .lookup(lookup), .fill(fill),
    .upd_v_o(upd_v), .upd_index_o(upd_index), .upd_way_o(upd_way),
    .vic_index_o(vic_index), .way_valid_o(way_valid), .victim_way_i(victim_way)
  );

  icache_tag_array #(.sets_p(sets_p), .assoc_p(assoc_p), .block_width_p(block_width_p)) tags
  (
    .clk_i(clk_i), .reset_i(reset_i), .lookup(lookup), .fill(fill)
  );

  icache_data_array #(.sets_p(sets_p), .assoc_p(assoc_p), .block_width_p(block_width_p)) data
  (
    .clk_i(clk_i), .lookup(lookup), .fill(fill)
  );

  icache_lru #(.sets_p(sets_p), .assoc_p(assoc_p)) lru
  (
    .clk_i(clk_i), .reset_i(reset_i),
    .upd_v_i(upd_v), .upd_index_i(upd_index), .upd_way_i(upd_way),
    .vic_index_i(vic_index), .way_valid_i(way_valid), .victim_way_o(victim_way)
  );

endmodule

// File: bench/icache_mem_model.sv
/*
  Next-level memory model for the instruction cache testbench
  Accepts a miss request after a random delay, then returns the
  whole block in one beat. Each word holds its own byte address
  XOR a fixed pattern
*/

`timescale 1ns/10ps

module icache_mem_model
  #(parameter int block_width_p = icache_pkg::block_width_default_c)
  (input  logic                     clk_i,
   input  logic                     req_v_i,
   input  logic [31:0]              req_addr_i,
   output logic                     req_yumi_o,
   output logic                     fill_v_o,
   output logic [block_width_p-1:0] fill_data_o
  );

  localparam int words_c = block_width_p / 32;
  localparam logic [31:0] pattern_c = 32'hA5A50000;

  integer      seed = 99991;
  integer      delay;
  logic [31:0] addr;

  initial
  begin
    req_yumi_o  = 1'b0;
    fill_v_o    = 1'b0;
    fill_data_o = '0;
    forever
    begin
      @(negedge clk_i);
      if (req_v_i)
      begin
        addr  = req_addr_i;
        // Request accept after 1 to 4 cycles
        delay = 1 + ($random(seed) & 3);
        repeat (delay - 1) @(negedge clk_i);
        req_yumi_o = 1'b1;
        @(negedge clk_i);
        req_yumi_o = 1'b0;
        // Fill after 2 to 6 more cycles
        delay = 2 + ({$random(seed)} % 5);
        repeat (delay - 1) @(negedge clk_i);
        for (int w = 0; w < words_c; w++)
          fill_data_o[w*32 +: 32] = (addr + 32'(4 * w)) ^ pattern_c;
        fill_v_o = 1'b1;
        @(negedge clk_i);
        fill_v_o = 1'b0;
      end
    end
  end

endmodule

// File: bench/icache_tb.sv
/*
  Instruction cache testbench
  Drives fetches and invalidates into the DUT, keeps a reference
  model of tags, valid bits and LRU, and checks the responses
  with concurrent assertions against a queue of expected results
*/

`timescale 1ns/10ps

module icache_tb;

  import icache_pkg::*;

  localparam int tag_w = 22;
  localparam logic [31:0] pattern_c = 32'hA5A50000;

  logic clk_i = 1'b0;
  logic reset_i = 1'b1;
  logic [31:0] vaddr_i = '0;
  icache_op_e op_i = e_fetch;
  logic v_i = 1'b0;
  logic [tag_w-1:0] ptag_i = '0;
  logic yumi_i = 1'b0;
  logic yumi_o, data_v_o, fence_v_o, req_v_o, req_yumi_i, fill_v_i;
  logic [31:0] data_o, req_addr_o;
  logic [127:0] fill_data_i;

  // Reference model of tags, valid bits and LRU
  logic [tag_w-1:0] m_tag [64][2];
  bit m_valid [64][2];
  bit m_lru [64];
  // Expected kind per request is 0 for a hit, 1 for a miss and 2 for an invalidate
  logic [31:0] exp_data_q[$];
  logic [31:0] exp_addr_q[$];
  int exp_kind_q[$];
  logic [31:0] head_data, head_addr;
  int head_kind, head_count;
  bit head_req_seen, consume_pend, yumi_random, timing_mode;
  int issued_cnt, resp_cnt, cycles;
  integer seed = 99991;

  always #20 clk_i = ~clk_i;

  icache_top UUT
  (
    .clk_i(clk_i), .reset_i(reset_i), .vaddr_i(vaddr_i), .op_i(op_i), .v_i(v_i),
    .yumi_o(yumi_o), .ptag_i(ptag_i), .data_o(data_o), .data_v_o(data_v_o),
    .fence_v_o(fence_v_o), .yumi_i(yumi_i), .req_v_o(req_v_o), .req_addr_o(req_addr_o),
    .req_yumi_i(req_yumi_i), .fill_v_i(fill_v_i), .fill_data_i(fill_data_i)
  );

  icache_mem_model mem
  (
    .clk_i(clk_i), .req_v_i(req_v_o), .req_addr_i(req_addr_o),
    .req_yumi_o(req_yumi_i), .fill_v_o(fill_v_i), .fill_data_o(fill_data_i)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    abort_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
  endtask

  // Returns 1 on a miss and updates tags, valid bits and LRU
  function automatic int model_fetch(input logic [31:0] addr);
    int idx;
    int way;
    idx = int'(addr[9:4]);
    way = -1;
    for (int w = 0; w < 2; w++)
      if (m_valid[idx][w] && m_tag[idx][w] == addr[31:10])
        way = w;
    if (way >= 0)
    begin
      m_lru[idx] = (way == 0);
      return 0;
    end
    way = !m_valid[idx][0] ? 0 : (!m_valid[idx][1] ? 1 : int'(m_lru[idx]));
    m_tag[idx][way] = addr[31:10];
    m_valid[idx][way] = 1'b1;
    m_lru[idx] = (way == 0);
    return 1;
  endfunction

  task automatic issue(input logic [31:0] addr, input icache_op_e op);
    if (op == e_inval)
    begin
      foreach (m_valid[s, w])
        m_valid[s][w] = 1'b0;
      exp_kind_q.push_back(2);
    end
    else
      exp_kind_q.push_back(model_fetch(addr));
    exp_data_q.push_back({addr[31:2], 2'b00} ^ pattern_c);
    exp_addr_q.push_back({addr[31:4], 4'h0});
    issued_cnt++;
    vaddr_i = addr;
    op_i = op;
    v_i = 1'b1;
    forever
    begin
      #1;
      if (yumi_o)
        break;
      @(negedge clk_i);
    end
    @(negedge clk_i);
    // Entry now sits in TL and its physical tag equals the virtual one
    ptag_i = addr[31:10];
    v_i = 1'b0;
  endtask

  task automatic drain();
    while (exp_kind_q.size() != 0)
    begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
  endtask

  // Pops the expected queue one cycle after the DUT has taken a response
  always @(negedge clk_i)
  begin
    if (consume_pend)
    begin
      void'(exp_data_q.pop_front());
      void'(exp_addr_q.pop_front());
      void'(exp_kind_q.pop_front());
      resp_cnt++;
      head_req_seen = 1'b0;
    end
    if (req_v_o)
      head_req_seen = 1'b1;
    head_count = exp_kind_q.size();
    if (head_count > 0)
    begin
      head_data = exp_data_q[0];
      head_addr = exp_addr_q[0];
      head_kind = exp_kind_q[0];
    end
    yumi_i = yumi_random ? (($random(seed) & 3) != 0) : 1'b1;
    consume_pend = (data_v_o || fence_v_o) && yumi_i;
  end

  //////////////////////////////
  // Checks
  //////////////////////////////
  a_reset_out: assert property (@(posedge clk_i) $fell(reset_i) |->
    !yumi_o && !data_v_o && !fence_v_o && !req_v_o)
    else abort_run("Outputs not low after reset");

  a_data: assert property (@(posedge clk_i) disable iff (reset_i)
    data_v_o && yumi_i |-> data_o == head_data)
    else report_mismatch("data_o", $sampled(data_o), $sampled(head_data));

  a_data_order: assert property (@(posedge clk_i) disable iff (reset_i)
    data_v_o |-> head_count > 0 && head_kind != 2 && (head_kind == 0 || head_req_seen))
    else abort_run("Fetch response does not match the oldest request");

  a_fence: assert property (@(posedge clk_i) disable iff (reset_i)
    fence_v_o |-> head_count > 0 && head_kind == 2)
    else abort_run("Fence response without a pending invalidate");

  a_req_kind: assert property (@(posedge clk_i) disable iff (reset_i)
    req_v_o |-> head_count > 0 && head_kind == 1)
    else abort_run("Miss request for a block the reference model holds");

  a_req_addr: assert property (@(posedge clk_i) disable iff (reset_i)
    req_v_o |-> req_addr_o == head_addr)
    else report_mismatch("req_addr_o", $sampled(req_addr_o), $sampled(head_addr));

  a_hit_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    timing_mode && yumi_o |-> ##2 data_v_o)
    else abort_run("Hit response not two cycles after acceptance");

  a_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    data_v_o && !yumi_i |=> $stable(data_o))
    else abort_run("data_o changed while waiting for yumi_i");

  // Watchdog allows 200 cycles per request plus the power-up sweep
  initial
  begin
    while (cycles <= 200 * (issued_cnt + 2))
    begin
      @(posedge clk_i);
      cycles++;
    end
    abort_run("Timeout waiting for the DUT");
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial
  begin
    logic [31:0] addr;
    foreach (m_valid[s, w])
      m_valid[s][w] = 1'b0;
    foreach (m_lru[s])
      m_lru[s] = 1'b0;
    repeat (5) @(negedge clk_i);
    reset_i = 1'b0;
    // Cold miss, then a hit in the same block
    issue(32'h0000_1048, e_fetch);
    issue(32'h0000_1044, e_fetch);
    drain();
    // Hit latency with no back-pressure
    timing_mode = 1'b1;
    issue(32'h0000_1040, e_fetch);
    issue(32'h0000_104C, e_fetch);
    drain();
    timing_mode = 1'b0;
    // Three tags into set 5 and a revisit from the newest down to the evicted one
    for (int t = 1; t <= 3; t++)
      issue({22'(t), 6'd5, 4'h4}, e_fetch);
    for (int t = 3; t >= 1; t--)
      issue({22'(t), 6'd5, 4'h8}, e_fetch);
    drain();
    // Invalidate so that everything misses afterwards
    issue(32'h0, e_inval);
    issue(32'h0000_1040, e_fetch);
    issue({22'd3, 6'd5, 4'h0}, e_fetch);
    drain();
    // Random traffic with back-pressure
    yumi_random = 1'b1;
    for (int i = 0; i < 40; i++)
    begin
      addr = {22'(8 + ($random(seed) & 3)), 6'(2 + ($random(seed) & 1)),
              2'($random(seed)), 2'b00};
      issue(addr, (i == 20) ? e_inval : e_fetch);
    end
    drain();
    if (resp_cnt != issued_cnt)
      abort_run("Response count differs from request count");
    else
    begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

// File: vlog.f
src/icache_pkg.sv
src/icache_if.sv
src/icache_tag_array.sv
src/icache_data_array.sv
src/icache_lru.sv
src/icache_ctrl.sv
src/icache_top.sv
bench/icache_mem_model.sv
bench/icache_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module icache_tb -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vicache_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

exit 0
